// File: common/pkt_pkg.sv
package pkt_pkg;

    // ====================
    // Beat geometry
    // ====================
    localparam int data_byte_wid = 8;
    localparam int data_wid = data_byte_wid * 8;
    localparam int mty_wid = $clog2(data_byte_wid);

    // One 64-bit beat of packet data
    typedef logic [data_wid-1:0] data_t;

    // Empty byte count in the last beat
    typedef logic [mty_wid-1:0] mty_t;

    // ====================
    // Metadata
    // ====================
    typedef logic [31:0] meta_t;

    // ====================
    // Input beat
    // ====================
    // Big endian lanes, byte 0 lives in data[63:56]
    typedef struct packed {
        data_t data;
        logic  eop;
        // Unused bytes at the tail of the last beat
        mty_t  mty;
        // Only meaningful together with eop
        meta_t meta;
    } pkt_beat_t;

endpackage

// File: common/capture_pkg.sv
package capture_pkg;

    // ====================
    // Buffer sizes
    // ====================
    localparam int mem_words = 256;
    localparam int mem_addr_wid = $clog2(mem_words);
    localparam int desc_depth = 16;
    localparam int desc_ptr_wid = $clog2(desc_depth);

    typedef logic [mem_addr_wid-1:0] mem_addr_t;
    typedef logic [desc_ptr_wid-1:0] desc_ptr_t;

    // Counts reach the full depth so they carry one extra bit
    typedef logic [mem_addr_wid:0] words_t;
    typedef logic [desc_ptr_wid:0] desc_cnt_t;
    typedef logic [15:0] drop_cnt_t;

    // Byte length 1 to 2048
    typedef logic [11:0] len_t;

    typedef struct packed {
        mem_addr_t      start;
        len_t           len;
        pkt_pkg::meta_t meta;
    } desc_t;

    // ====================
    // Wishbone
    // ====================
    localparam int wb_adr_wid = 12;
    localparam int wb_dat_wid = 32;

    typedef logic [wb_adr_wid-1:0] wb_adr_t;
    typedef logic [wb_dat_wid-1:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // Register map in word addresses
    localparam wb_adr_t reg_mem_size   = 12'd0;
    localparam wb_adr_t reg_meta_width = 12'd1;
    localparam wb_adr_t reg_status     = 12'd2;
    localparam wb_adr_t reg_desc_addr  = 12'd3;
    localparam wb_adr_t reg_desc_len   = 12'd4;
    localparam wb_adr_t reg_desc_meta  = 12'd5;
    localparam wb_adr_t reg_release    = 12'd6;

    // Two window words per packet word, high half first
    localparam wb_adr_t win_base = 12'h400;

endpackage

// File: packet_capture/capture_ram.sv
`timescale 1ns/1ps

module capture_ram #(
    parameter int  depth = 256,
    parameter type word_t = logic [63:0]
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output word_t                    rdata
);

    word_t mem [depth];

    // Write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old data on a same-cycle collision
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// File: packet_capture/capture_writer.sv
`timescale 1ns/1ps

module capture_writer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  pkt_pkg::pkt_beat_t     in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output logic                   mem_we,
    output capture_pkg::mem_addr_t mem_waddr,
    output pkt_pkg::data_t         mem_wdata,
    output logic                   desc_we,
    output capture_pkg::desc_ptr_t desc_waddr,
    output capture_pkg::desc_t     desc_wdata,
    input  logic                   release_pulse,
    input  capture_pkg::words_t    release_words,
    output capture_pkg::desc_cnt_t desc_count,
    output capture_pkg::drop_cnt_t drop_count
);

    // ====================
    // State
    // ====================
    logic                   first_q;
    logic                   discard_q;
    logic                   drop_q;
    capture_pkg::mem_addr_t tent_head;
    capture_pkg::mem_addr_t commit_head;
    capture_pkg::desc_ptr_t desc_head;
    capture_pkg::words_t    used_words;
    capture_pkg::words_t    pkt_words;
    capture_pkg::len_t      byte_cnt;

    logic                   accept;
    logic                   ring_full;
    logic                   discard_now;
    logic                   drop_now;
    logic                   commit;
    logic                   abandon;
    capture_pkg::words_t    words_next;
    logic [$bits(capture_pkg::words_t):0] words_need;
    capture_pkg::len_t      beat_bytes;
    capture_pkg::len_t      bytes_next;
    capture_pkg::words_t    words_add;
    capture_pkg::words_t    words_sub;

    assign accept = in_valid && in_ready;
    assign ring_full = (desc_count == capture_pkg::desc_cnt_t'(capture_pkg::desc_depth));

    // ====================
    // Per-beat decisions
    // ====================
    always_comb
    begin
        // Discard and ring-full status are sampled on the first beat only
        discard_now = first_q ? !en : discard_q;
        words_next  = (first_q ? capture_pkg::words_t'(0) : pkt_words) + 1'b1;
        words_need  = {1'b0, used_words} + {1'b0, words_next};
        drop_now    = (first_q ? ring_full : drop_q) ||
                      (words_need > capture_pkg::mem_words);

        if (in_beat.eop)
        begin
            beat_bytes = capture_pkg::len_t'(pkt_pkg::data_byte_wid) -
                         capture_pkg::len_t'(in_beat.mty);
        end
        else
        begin
            beat_bytes = capture_pkg::len_t'(pkt_pkg::data_byte_wid);
        end
        bytes_next = (first_q ? capture_pkg::len_t'(0) : byte_cnt) + beat_bytes;
    end

    assign commit  = accept && in_beat.eop && !discard_now && !drop_now;
    assign abandon = accept && in_beat.eop && !discard_now && drop_now;

    assign words_add = commit ? words_next : '0;
    assign words_sub = release_pulse ? release_words : '0;

    // Memory and descriptor write ports
    assign mem_we     = accept && !discard_now && !drop_now;
    assign mem_waddr  = tent_head;
    assign mem_wdata  = in_beat.data;
    assign desc_we    = commit;
    assign desc_waddr = desc_head;
    assign desc_wdata = '{start: commit_head, len: bytes_next, meta: in_beat.meta};

    // ====================
    // Control registers
    // ====================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_ready    <= 1'b0;
            first_q     <= 1'b1;
            discard_q   <= 1'b0;
            drop_q      <= 1'b0;
            tent_head   <= '0;
            commit_head <= '0;
            desc_head   <= '0;
            used_words  <= '0;
            desc_count  <= '0;
            drop_count  <= '0;
        end
        else
        begin
            in_ready <= 1'b1;

            if (accept)
            begin
                first_q   <= in_beat.eop;
                discard_q <= discard_now;
                drop_q    <= drop_now;
            end

            if (mem_we)
            begin
                tent_head <= tent_head + 1'b1;
            end

            if (commit)
            begin
                commit_head <= tent_head + 1'b1;
                desc_head   <= desc_head + 1'b1;
            end
            else if (abandon)
            begin
                // Roll back whatever the dropped packet wrote
                tent_head <= commit_head;
            end

            used_words <= used_words + words_add - words_sub;
            desc_count <= desc_count + capture_pkg::desc_cnt_t'(commit) -
                          capture_pkg::desc_cnt_t'(release_pulse);

            if (abandon)
            begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Running packet size
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            pkt_words <= words_next;
            byte_cnt  <= bytes_next;
        end
    end

endmodule

// File: verilog/capture_regs.sv
`timescale 1ns/1ps

module capture_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  capture_pkg::wb_req_t   wb_req,
    output capture_pkg::wb_rsp_t   wb_rsp,
    output capture_pkg::desc_ptr_t desc_raddr,
    input  capture_pkg::desc_t     desc_rdata,
    output capture_pkg::mem_addr_t mem_raddr,
    input  pkt_pkg::data_t         mem_rdata,
    input  capture_pkg::desc_cnt_t desc_count,
    input  capture_pkg::drop_cnt_t drop_count,
    output logic                   release_pulse,
    output capture_pkg::words_t    release_words
);

    logic                   start;
    logic                   is_win;
    logic                   rel_req;
    logic                   win_pend;
    logic                   ack_q;
    capture_pkg::wb_dat_t   dat_q;
    capture_pkg::wb_dat_t   reg_rdata;
    capture_pkg::wb_dat_t   win_rdata;
    capture_pkg::wb_adr_t   win_off;
    capture_pkg::desc_ptr_t tail;
    logic [$bits(capture_pkg::len_t):0] len_round;

    // New access only when nothing is in flight
    assign start = wb_req.cyc && wb_req.stb && !ack_q && !win_pend;
    assign is_win = (wb_req.adr >= capture_pkg::win_base);

    // ====================
    // Memory window
    // ====================
    assign win_off   = wb_req.adr - capture_pkg::win_base;
    assign mem_raddr = win_off[capture_pkg::mem_addr_wid:1];
    assign win_rdata = win_off[0] ? mem_rdata[31:0] : mem_rdata[63:32];

    // ====================
    // Descriptor tail
    // ====================
    // Look ahead so the RAM output follows the tail without a gap
    assign desc_raddr = tail + capture_pkg::desc_ptr_t'(release_pulse);

    // Bytes rounded up to whole words
    assign len_round     = {1'b0, desc_rdata.len} + 7'd7;
    assign release_words = len_round[$bits(capture_pkg::len_t)-1:3];

    assign rel_req = wb_req.we && (wb_req.adr == capture_pkg::reg_release) &&
                     (desc_count != '0);

    // Register read mux
    always_comb
    begin
        case (wb_req.adr)
            capture_pkg::reg_mem_size:
                reg_rdata = 32'(capture_pkg::mem_words * pkt_pkg::data_byte_wid);
            capture_pkg::reg_meta_width:
                reg_rdata = 32'($bits(pkt_pkg::meta_t));
            capture_pkg::reg_status:
                reg_rdata = {drop_count, 11'd0, desc_count};
            capture_pkg::reg_desc_addr:
                reg_rdata = 32'(desc_rdata.start);
            capture_pkg::reg_desc_len:
                reg_rdata = 32'(desc_rdata.len);
            capture_pkg::reg_desc_meta:
                reg_rdata = desc_rdata.meta;
            default:
                reg_rdata = '0;
        endcase
    end

    // ====================
    // Bus handshake
    // ====================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ack_q         <= 1'b0;
            win_pend      <= 1'b0;
            release_pulse <= 1'b0;
            tail          <= '0;
        end
        else
        begin
            ack_q         <= 1'b0;
            release_pulse <= 1'b0;

            if (win_pend)
            begin
                ack_q    <= 1'b1;
                win_pend <= 1'b0;
            end
            else if (start)
            begin
                if (is_win && !wb_req.we)
                begin
                    // Wait one more cycle for the data RAM
                    win_pend <= 1'b1;
                end
                else
                begin
                    ack_q         <= 1'b1;
                    release_pulse <= rel_req;
                end
            end

            if (release_pulse)
            begin
                tail <= tail + 1'b1;
            end
        end
    end

    // Read data
    always_ff @(posedge clk)
    begin
        if (win_pend)
        begin
            dat_q <= win_rdata;
        end
        else if (start)
        begin
            dat_q <= reg_rdata;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

// File: packet_capture/packet_capture.sv
`timescale 1ns/1ps

module packet_capture (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  pkt_pkg::pkt_beat_t     in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  capture_pkg::wb_req_t   wb_req,
    output capture_pkg::wb_rsp_t   wb_rsp,
    output capture_pkg::drop_cnt_t drop_count
);

    logic                   mem_we;
    capture_pkg::mem_addr_t mem_waddr;
    pkt_pkg::data_t         mem_wdata;
    capture_pkg::mem_addr_t mem_raddr;
    pkt_pkg::data_t         mem_rdata;

    logic                   desc_we;
    capture_pkg::desc_ptr_t desc_waddr;
    capture_pkg::desc_t     desc_wdata;
    capture_pkg::desc_ptr_t desc_raddr;
    capture_pkg::desc_t     desc_rdata;

    logic                   release_pulse;
    capture_pkg::words_t    release_words;
    capture_pkg::desc_cnt_t desc_count;

    // ====================
    // Write side
    // ====================
    capture_writer writer0 (
        .clk           ( clk ),
        .rst_n         ( rst_n ),
        .en            ( en ),
        .in_beat       ( in_beat ),
        .in_valid      ( in_valid ),
        .in_ready      ( in_ready ),
        .mem_we        ( mem_we ),
        .mem_waddr     ( mem_waddr ),
        .mem_wdata     ( mem_wdata ),
        .desc_we       ( desc_we ),
        .desc_waddr    ( desc_waddr ),
        .desc_wdata    ( desc_wdata ),
        .release_pulse ( release_pulse ),
        .release_words ( release_words ),
        .desc_count    ( desc_count ),
        .drop_count    ( drop_count )
    );

    // ====================
    // Storage
    // ====================
    capture_ram #(
        .depth  ( capture_pkg::mem_words ),
        .word_t ( pkt_pkg::data_t )
    ) data_ram0 (
        .clk   ( clk ),
        .we    ( mem_we ),
        .waddr ( mem_waddr ),
        .wdata ( mem_wdata ),
        .raddr ( mem_raddr ),
        .rdata ( mem_rdata )
    );

    capture_ram #(
        .depth  ( capture_pkg::desc_depth ),
        .word_t ( capture_pkg::desc_t )
    ) desc_ram0 (
        .clk   ( clk ),
        .we    ( desc_we ),
        .waddr ( desc_waddr ),
        .wdata ( desc_wdata ),
        .raddr ( desc_raddr ),
        .rdata ( desc_rdata )
    );

    // ====================
    // Software port
    // ====================
    capture_regs regs0 (
        .clk           ( clk ),
        .rst_n         ( rst_n ),
        .wb_req        ( wb_req ),
        .wb_rsp        ( wb_rsp ),
        .desc_raddr    ( desc_raddr ),
        .desc_rdata    ( desc_rdata ),
        .mem_raddr     ( mem_raddr ),
        .mem_rdata     ( mem_rdata ),
        .desc_count    ( desc_count ),
        .drop_count    ( drop_count ),
        .release_pulse ( release_pulse ),
        .release_words ( release_words )
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int half_period = 2;
    localparam int reset_cycles = 8;

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Synchronous reset, released just after the last reset edge
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: testbench/packet_capture_properties.sv
`timescale 1ns/1ps

module packet_capture_properties (
    input logic                 clk,
    input logic                 rst_n,
    input capture_pkg::wb_req_t wb_req,
    input capture_pkg::wb_rsp_t wb_rsp,
    input logic                 in_ready
);

    // ====================
    // Wishbone handshake
    // ====================
    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack seen outside an active bus cycle");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held high for two cycles");

    // Stream input stays closed through reset
    ready_after_reset: assert property (@(posedge clk)
        !rst_n |=> !in_ready)
        else $error("in_ready high in the cycle after reset");

endmodule

bind packet_capture packet_capture_properties props0 (
    .clk      ( clk ),
    .rst_n    ( rst_n ),
    .wb_req   ( wb_req ),
    .wb_rsp   ( wb_rsp ),
    .in_ready ( in_ready )
);

// File: testbench/packet_capture_model.svh
`ifndef packet_capture_model_svh
`define packet_capture_model_svh

// ====================
// Buffer model
// ====================
capture_pkg::desc_t desc_q[$];
pkt_pkg::data_t     mem_image[capture_pkg::mem_words];
int                 head_word;
int                 used_words;
int                 exp_drops;

function automatic void reset_model();
    desc_q.delete();
    head_word  = 0;
    used_words = 0;
    exp_drops  = 0;
    // Address in every byte so stale words stand out
    for (int i = 0; i < capture_pkg::mem_words; i++)
    begin
        mem_image[i] = {8{8'(i)}};
    end
endfunction

// Returns 1 when the packet lands in the buffer
function automatic bit store_packet(input bit en_start, input pkt_pkg::data_t data[$],
                                    input int len, input pkt_pkg::meta_t meta);
    capture_pkg::desc_t d;
    int                 words;
    words = data.size();
    // Packets that start while disabled are not even counted
    if (!en_start)
    begin
        return 1'b0;
    end
    if (desc_q.size() == capture_pkg::desc_depth ||
        used_words + words > capture_pkg::mem_words)
    begin
        exp_drops++;
        return 1'b0;
    end
    for (int k = 0; k < words; k++)
    begin
        mem_image[(head_word + k) % capture_pkg::mem_words] = data[k];
    end
    d.start = capture_pkg::mem_addr_t'(head_word);
    d.len   = capture_pkg::len_t'(len);
    d.meta  = meta;
    desc_q.push_back(d);
    head_word  = (head_word + words) % capture_pkg::mem_words;
    used_words = used_words + words;
    return 1'b1;
endfunction

function automatic void pop_oldest();
    capture_pkg::desc_t d;
    if (desc_q.size() != 0)
    begin
        d = desc_q.pop_front();
        used_words = used_words - (int'(d.len) + 7) / 8;
    end
endfunction

// Drops in the top half, ring occupancy in the low bits
function automatic capture_pkg::wb_dat_t status_word();
    return {16'(exp_drops), 11'd0, 5'(desc_q.size())};
endfunction

`endif

// File: testbench/packet_capture_tb.sv
`timescale 1ns/1ps

module packet_capture_tb;

    // ====================
    // Run length
    // ====================
    localparam int max_len = 300;
    localparam int small_len = 16;
    localparam int max_beats = (max_len + 7) / 8;
    // Status, three descriptor reads, two window reads per word, release
    localparam int pkt_access = 2 * max_beats + 5;
    localparam int stream_pkts = 50;
    localparam int fill_pkts = 20;
    localparam int en_pkts = 3;
    localparam int test_work = 3 + (stream_pkts + 2) * (max_beats + pkt_access) +
                               2 * fill_pkts * (max_beats + pkt_access) +
                               en_pkts * (max_beats + 1);
    localparam int cycle_limit = test_work * 4 + 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    pkt_pkg::pkt_beat_t     in_beat;
    logic                   in_valid;
    logic                   in_ready;
    capture_pkg::wb_req_t   wb_req;
    capture_pkg::wb_rsp_t   wb_rsp;
    capture_pkg::drop_cnt_t drop_count;

    integer         seed;
    int             errors;
    int             checks;
    int             cycles;
    pkt_pkg::data_t pkt_data[$];
    int             pkt_len;
    pkt_pkg::meta_t pkt_meta;

    `include "packet_capture_model.svh"

    tb_clock clock0 (
        .clk   ( clk ),
        .rst_n ( rst_n )
    );

    packet_capture dut0 (
        .clk        ( clk ),
        .rst_n      ( rst_n ),
        .en         ( en ),
        .in_beat    ( in_beat ),
        .in_valid   ( in_valid ),
        .in_ready   ( in_ready ),
        .wb_req     ( wb_req ),
        .wb_rsp     ( wb_rsp ),
        .drop_count ( drop_count )
    );

    // ====================
    // Helpers
    // ====================
    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("Test %s finished with %0d errors", name, errors - err0);
    endtask

    // One classic cycle with the strobe held through the ack cycle
    task automatic bus_cycle(input logic we, input capture_pkg::wb_adr_t adr,
                             input capture_pkg::wb_dat_t wdat,
                             output capture_pkg::wb_dat_t rdat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    function automatic void build_packet(input int max_bytes);
        pkt_pkg::data_t word;
        int             beats;
        pkt_len  = 1 + int'($unsigned($random(seed)) % max_bytes);
        pkt_meta = $random(seed);
        beats    = (pkt_len + 7) / 8;
        pkt_data.delete();
        for (int i = 0; i < beats; i++)
        begin
            word = '0;
            for (int b = 0; b < pkt_pkg::data_byte_wid; b++)
            begin
                // Byte 0 of each beat in the top lane
                if (i * 8 + b < pkt_len)
                begin
                    word[63 - 8 * b -: 8] = 8'($random(seed));
                end
            end
            pkt_data.push_back(word);
        end
    endfunction

    // en follows en_start on the first beat and is high afterwards
    task automatic send_packet(input logic en_start);
        int   n;
        logic ready_seen;
        n  = pkt_data.size();
        en = en_start;
        for (int i = 0; i < n; i++)
        begin
            in_beat.data = pkt_data[i];
            in_beat.eop  = (i == n - 1);
            in_beat.mty  = (i == n - 1) ? pkt_pkg::mty_t'(n * 8 - pkt_len) : '0;
            in_beat.meta = (i == n - 1) ? pkt_meta : '0;
            in_valid     = 1'b1;
            do
            begin
                ready_seen = in_ready;
                @(posedge clk);
                #1;
            end
            while (!ready_seen);
            en = 1'b1;
        end
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task automatic expect_status();
        capture_pkg::wb_dat_t rd;
        bus_cycle(1'b0, capture_pkg::reg_status, '0, rd);
        compare_value("reg_status", rd, status_word());
        compare_value("drop_count", drop_count, 16'(exp_drops));
    endtask

    task automatic verify_oldest();
        capture_pkg::desc_t     exp;
        capture_pkg::wb_dat_t   rd;
        capture_pkg::wb_dat_t   lo;
        capture_pkg::mem_addr_t addr;
        exp = desc_q[0];
        bus_cycle(1'b0, capture_pkg::reg_desc_addr, '0, rd);
        compare_value("desc_addr", rd, exp.start);
        bus_cycle(1'b0, capture_pkg::reg_desc_len, '0, rd);
        compare_value("desc_len", rd, exp.len);
        bus_cycle(1'b0, capture_pkg::reg_desc_meta, '0, rd);
        compare_value("desc_meta", rd, exp.meta);
        for (int k = 0; k < (int'(exp.len) + 7) / 8; k++)
        begin
            // 8-bit word address wraps at the end of the buffer
            addr = exp.start + capture_pkg::mem_addr_t'(k);
            bus_cycle(1'b0, capture_pkg::win_base + 12'(2 * int'(addr)), '0, rd);
            bus_cycle(1'b0, capture_pkg::win_base + 12'(2 * int'(addr) + 1), '0, lo);
            compare_value("window_word", {rd, lo}, mem_image[addr]);
        end
    endtask

    task automatic free_oldest();
        capture_pkg::wb_dat_t rd;
        bus_cycle(1'b1, capture_pkg::reg_release, '0, rd);
        pop_oldest();
    endtask

    task automatic drain_ring();
        while (desc_q.size() != 0)
        begin
            verify_oldest();
            free_oldest();
        end
        expect_status();
    endtask

    // ====================
    // Tests
    // ====================
    task automatic reset_state();
        int err0;
        err0 = errors;
        // Inside reset the stream input is closed and the bus idle
        @(posedge clk);
        #1;
        compare_value("in_ready", in_ready, 0);
        compare_value("wb_ack", wb_rsp.ack, 0);
        @(posedge rst_n);
        @(posedge clk);
        #1;
        // Open from the first cycle after reset
        compare_value("in_ready", in_ready, 1);
        compare_value("wb_ack", wb_rsp.ack, 0);
        compare_value("drop_count", drop_count, 0);
        report_test("reset", err0);
    endtask

    task automatic info_regs();
        capture_pkg::wb_dat_t rd;
        int                   err0;
        err0 = errors;
        bus_cycle(1'b0, capture_pkg::reg_mem_size, '0, rd);
        compare_value("reg_mem_size", rd, 2048);
        bus_cycle(1'b0, capture_pkg::reg_meta_width, '0, rd);
        compare_value("reg_meta_width", rd, 32);
        report_test("info", err0);
    endtask

    task automatic idle_state();
        capture_pkg::wb_dat_t rd;
        int                   err0;
        err0 = errors;
        bus_cycle(1'b0, capture_pkg::reg_status, '0, rd);
        compare_value("reg_status", rd, 0);
        compare_value("drop_count", drop_count, 0);
        report_test("nop", err0);
    endtask

    task automatic packet_stream(input string name, input int count);
        bit stored;
        int err0;
        err0 = errors;
        for (int i = 0; i < count; i++)
        begin
            build_packet(max_len);
            send_packet(1'b1);
            stored = store_packet(1'b1, pkt_data, pkt_len, pkt_meta);
            expect_status();
            if (stored)
            begin
                verify_oldest();
                free_oldest();
            end
        end
        expect_status();
        report_test(name, err0);
    endtask

    task automatic overflow_fill();
        int err0;
        err0 = errors;
        // Large packets fill the memory first
        for (int i = 0; i < fill_pkts; i++)
        begin
            build_packet(max_len);
            send_packet(1'b1);
            void'(store_packet(1'b1, pkt_data, pkt_len, pkt_meta));
            expect_status();
        end
        drain_ring();
        // Short packets run the descriptor ring full
        for (int i = 0; i < fill_pkts; i++)
        begin
            build_packet(small_len);
            send_packet(1'b1);
            void'(store_packet(1'b1, pkt_data, pkt_len, pkt_meta));
            expect_status();
        end
        drain_ring();
        report_test("overflow", err0);
    endtask

    task automatic enable_gate();
        int err0;
        err0 = errors;
        for (int i = 0; i < en_pkts; i++)
        begin
            build_packet(max_len);
            send_packet(1'b0);
            void'(store_packet(1'b0, pkt_data, pkt_len, pkt_meta));
            expect_status();
        end
        build_packet(max_len);
        send_packet(1'b1);
        void'(store_packet(1'b1, pkt_data, pkt_len, pkt_meta));
        expect_status();
        drain_ring();
        report_test("enable", err0);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial
    begin : main
        seed     = 32'had48;
        errors   = 0;
        checks   = 0;
        en       = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        wb_req   = '0;
        reset_model();
        reset_state();
        info_regs();
        idle_state();
        packet_stream("single", 1);
        packet_stream("stream", stream_pkts);
        overflow_fill();
        enable_gate();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial
    begin : watchdog
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a handshake never completed", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: all.f
+incdir+testbench
common/pkt_pkg.sv
common/capture_pkg.sv
packet_capture/capture_ram.sv
packet_capture/capture_writer.sv
verilog/capture_regs.sv
packet_capture/packet_capture.sv
testbench/tb_clock.sv
testbench/packet_capture_properties.sv
testbench/packet_capture_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= packet_capture_tb
FILE_LIST ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
